//--- sync_defines.svh
// sync unit timing constants
`ifndef SYNC_DEFINES_SVH
`define SYNC_DEFINES_SVH

// ----------------------------------------------------------------------
// time base
// ----------------------------------------------------------------------

// clk cycles in one sync bit
`define SYNC_BIT_CYC     5

// sync bits in one frame
`define SYNC_FRAME_BITS  10

// frames in one second, so a second is 5 * 10 * 4 = 200 clk
`define SYNC_FRAMES      4

// ----------------------------------------------------------------------
// strobe and pulse lengths
// ----------------------------------------------------------------------

`define SYNC_ST_S        2     // sync strobe bits, ordinary frame
`define SYNC_ST_0S       5     // sync strobe bits, last frame of second
`define SYNC_PULSE_CYC   30    // stretched 1s / 1m output length

// counter widths
`define SYNC_BIT_W       3     // holds 0..SYNC_BIT_CYC-1
`define SYNC_FRAME_W     4     // holds 0..SYNC_FRAME_BITS-1
`define SYNC_NFR_W       8     // frame index, also o_n_sync

`endif

//--- sync_pkg.sv
// sync unit types

package sync_pkg;

   // ----------------------------------------------------------------------
   // reference source, code 2'b11 behaves as free running
   // ----------------------------------------------------------------------
   typedef enum logic [1:0] {
      SRC_FREE = 2'b00,   // own counters only
      SRC_PPS  = 2'b01,   // gps pps input
      SRC_EXT  = 2'b10    // external one second input
   } sync_src_e;

   // ----------------------------------------------------------------------
   // time word as seen by the host
   // ----------------------------------------------------------------------
   // host writes use hours, minutes and seconds
   // overday and low are status fields
   typedef struct packed {
      logic        overday;   // set when hours roll past 23
      logic [4:0]  hours;     // 0..23
      logic [5:0]  minutes;   // 0..59
      logic [5:0]  seconds;   // 0..59
      logic [13:0] low;       // current frame index, zero extended
   } tod_t;

endpackage

//--- frame_if.sv
// frame position bus
`timescale 1ns/1ps
`include "sync_defines.svh"

interface frame_if;

   logic                      bit_tick;    // last clk of a sync bit
   logic [`SYNC_NFR_W-1:0]    frame_idx;   // frame within second
   logic [`SYNC_FRAME_W-1:0]  bit_idx;     // bit within frame
   logic                      sec_wrap;    // internal second wraps

   // frame timer owns the bus
   modport timer (
      output bit_tick,
      output frame_idx,
      output bit_idx,
      output sec_wrap
   );

   // time of day only needs frame index and wrap
   modport tod (
      input frame_idx,
      input sec_wrap
   );

   // monitors see everything
   modport mon (
      input bit_tick,
      input frame_idx,
      input bit_idx,
      input sec_wrap
   );

endinterface

//--- ref_edge_select.sv
// reference edge detect and select
`timescale 1ns/1ps

module ref_edge_select import sync_pkg::*; (
   input  logic      i_clk,
   input  logic      host_clk,         // async reset, active high
   input  logic      i_pps,
   input  logic      i_ext_1s,
   input  logic      i_ext_1m,
   input  logic      i_sync_iedge,     // 1 selects falling edges
   input  sync_src_e i_src,
   input  logic      i_load_pend,      // host word waiting in time_of_day
   input  logic      i_mode_set_time,  // 1 waits for the minute edge
   output logic      o_restart,
   output logic      o_minute
);

   // ----------------------------------------------------------------------
   // bit order in all vectors is {ext_1m, ext_1s, pps}
   // ----------------------------------------------------------------------
   logic [2:0] pin;
   logic [2:0] meta_q;     // first synchronizer stage
   logic [2:0] sync_q;     // second synchronizer stage
   logic [2:0] prev_q;     // last value, for edge compare
   logic [2:0] rise_q;
   logic [2:0] fall_q;
   logic [2:0] edge_sel;

   assign pin = {i_ext_1m, i_ext_1s, i_pps};

   // two flops, then a registered edge strobe
   // pin edge to strobe is 3 clk
   always_ff @(posedge i_clk or posedge host_clk) begin
      if (host_clk) begin
         meta_q <= '0;
         sync_q <= '0;
         prev_q <= '0;
         rise_q <= '0;
         fall_q <= '0;
      end else begin
         meta_q <= pin;
         sync_q <= meta_q;
         prev_q <= sync_q;
         rise_q <= sync_q & ~prev_q;
         fall_q <= ~sync_q & prev_q;
      end
   end

   assign edge_sel = i_sync_iedge ? fall_q : rise_q;   // polarity select

   // minute strobe stays high for immediate loads
   assign o_minute = i_mode_set_time ? edge_sel[2] : 1'b1;

   // ----------------------------------------------------------------------
   // restart source
   // ----------------------------------------------------------------------
   always_comb begin
      case (i_src)
         SRC_PPS: o_restart = edge_sel[0];
         SRC_EXT: o_restart = edge_sel[1];
         // free running, realign on the cycle the host word is taken
         default: o_restart = i_load_pend & o_minute;
      endcase
   end

endmodule

//--- frame_timer.sv
// bit, frame and second counters
`timescale 1ns/1ps
`include "sync_defines.svh"

module frame_timer import sync_pkg::*; (
   input  logic       clk,
   input  logic       host_clk,      // async reset, active high
   input  logic       i_restart,     // realign to bit 0 of frame 0
   input  sync_src_e  i_src,
   input  logic       i_wr_en,       // host write clears error count
   frame_if.timer     fb,
   output logic       o_sync,        // frame sync strobe
   output logic       o_sync_win,    // once per second window
   output logic       o_sec_carry,
   output logic [7:0] o_err_cnt
);

   logic [`SYNC_BIT_W-1:0]   bit_div;     // clk within bit
   logic [`SYNC_FRAME_W-1:0] bit_cnt;     // bit within frame
   logic [`SYNC_NFR_W-1:0]   frame_cnt;   // frame within second
   logic                     frame_end;
   logic                     last_frame;
   logic                     ref_mode;    // pps or external reference
   logic                     on_edge;     // first or last bit of second
   logic                     rst_d1;
   logic                     rst_d2;

   assign fb.bit_tick  = (bit_div == `SYNC_BIT_CYC - 1);
   assign frame_end    = fb.bit_tick && (bit_cnt == `SYNC_FRAME_BITS - 1);
   assign last_frame   = (frame_cnt == `SYNC_FRAMES - 1);
   assign fb.sec_wrap  = frame_end && last_frame;
   assign fb.bit_idx   = bit_cnt;
   assign fb.frame_idx = frame_cnt;

   assign ref_mode = (i_src == SRC_PPS) || (i_src == SRC_EXT);
   assign on_edge  = ((frame_cnt == 0) && (bit_cnt == 0)) ||
                     (last_frame && (bit_cnt == `SYNC_FRAME_BITS - 1));

   // ----------------------------------------------------------------------
   // counters, restart wins over counting
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge host_clk) begin
      if (host_clk) begin
         bit_div   <= '0;
         bit_cnt   <= '0;
         frame_cnt <= '0;
      end else if (i_restart) begin
         bit_div   <= '0;
         bit_cnt   <= '0;
         frame_cnt <= '0;
      end else if (fb.bit_tick) begin
         bit_div <= '0;
         if (frame_end) begin
            bit_cnt   <= '0;
            frame_cnt <= last_frame ? '0 : frame_cnt + 1'b1;   // second wraps
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         bit_div <= bit_div + 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // strobes, restart delay and error count
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge host_clk) begin
      if (host_clk) begin
         o_sync     <= 1'b0;
         o_sync_win <= 1'b0;
         rst_d1     <= 1'b0;
         rst_d2     <= 1'b0;
         o_err_cnt  <= '0;
      end else begin
         // long strobe marks the last frame of the second
         o_sync <= last_frame ? (bit_cnt < `SYNC_ST_0S) : (bit_cnt < `SYNC_ST_S);
         o_sync_win <= (frame_cnt == 0) && (bit_cnt == 0) && (bit_div == 0);
         rst_d1 <= i_restart;
         rst_d2 <= rst_d1;
         if (i_wr_en)
            o_err_cnt <= '0;
         else if (i_restart && ref_mode && !on_edge)
            o_err_cnt <= o_err_cnt + 1'b1;   // reference off position, wraps at 256
      end
   end

   // reference modes take the second from the reference edge
   assign o_sec_carry = ref_mode ? rst_d2 : fb.sec_wrap;

endmodule

//--- time_of_day.sv
// time of day counter with host load
`timescale 1ns/1ps
`include "sync_defines.svh"

module time_of_day import sync_pkg::*; (
   input  logic  clk,
   input  logic  host_clk,      // async reset, active high
   input  logic  i_wr_en,       // one clk host write strobe
   input  tod_t  i_wr_data,
   input  logic  i_minute,      // load enable, high in immediate mode
   input  logic  i_sec_carry,
   frame_if.tod  fb,
   output logic  o_load_pend,
   output tod_t  o_time,
   output logic  o_min_carry
);

   // latched host word
   logic [4:0]  wr_hours;
   logic [5:0]  wr_minutes;
   logic [5:0]  wr_seconds;

   // running time
   logic        overday;
   logic [4:0]  hours;
   logic [5:0]  minutes;
   logic [5:0]  seconds;
   logic [13:0] low_q;

   logic        load;        // take the latched word this clk
   logic        sec_last;
   logic        min_last;
   logic        hour_last;

   // ----------------------------------------------------------------------
   // host latch, a later write overwrites a pending one
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_wr_en) begin
         wr_hours   <= i_wr_data.hours;
         wr_minutes <= i_wr_data.minutes;
         wr_seconds <= i_wr_data.seconds;
      end
   end

   always_ff @(posedge clk or posedge host_clk) begin
      if (host_clk)
         o_load_pend <= 1'b0;
      else if (i_wr_en)
         o_load_pend <= 1'b1;
      else if (load)
         o_load_pend <= 1'b0;   // taken
   end

   assign load      = o_load_pend & i_minute;
   assign sec_last  = (seconds == 6'd59);
   assign min_last  = (minutes == 6'd59);
   assign hour_last = (hours == 5'd23);

   // ----------------------------------------------------------------------
   // seconds, minutes, hours
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge host_clk) begin
      if (host_clk) begin
         overday     <= 1'b0;
         hours       <= '0;
         minutes     <= '0;
         seconds     <= '0;
         o_min_carry <= 1'b0;
      end else if (load) begin
         overday     <= 1'b0;   // fresh day from host
         hours       <= wr_hours;
         minutes     <= wr_minutes;
         seconds     <= wr_seconds;
         o_min_carry <= 1'b0;
      end else begin
         o_min_carry <= i_sec_carry & sec_last;
         if (i_sec_carry) begin
            if (!sec_last) begin
               seconds <= seconds + 1'b1;
            end else begin
               seconds <= '0;
               if (!min_last) begin
                  minutes <= minutes + 1'b1;
               end else begin
                  minutes <= '0;
                  if (hour_last) begin
                     hours   <= '0;
                     overday <= 1'b1;   // sticky until next load
                  end else begin
                     hours <= hours + 1'b1;
                  end
               end
            end
         end
      end
   end

   // low field follows frame index, steps to 0 together with the second
   always_ff @(posedge clk or posedge host_clk) begin
      if (host_clk)
         low_q <= '0;
      else if (load || fb.sec_wrap)
         low_q <= '0;
      else
         low_q <= {{(14 - `SYNC_NFR_W){1'b0}}, fb.frame_idx};
   end

   always_comb begin
      o_time.overday = overday;
      o_time.hours   = hours;
      o_time.minutes = minutes;
      o_time.seconds = seconds;
      o_time.low     = low_q;
   end

endmodule

//--- pulse_stretch.sv
// carry to fixed length pulse
`timescale 1ns/1ps

module pulse_stretch #(
   parameter int PULSE_CYC = 30           // extra clk after the trigger clk
) (
   input  logic clk,
   input  logic host_clk,                 // async reset, active high
   input  logic i_trig,                   // one clk carry
   input  logic i_oedge,                  // idle level of o_pulse
   output logic o_pulse
);

   localparam int CNT_W = $clog2(PULSE_CYC + 1);

   logic [CNT_W-1:0] cnt;                 // clk left in pulse
   logic             active;

   // active for PULSE_CYC+1 clk, a new trigger restarts the count
   always_ff @(posedge clk or posedge host_clk) begin
      if (host_clk) begin
         cnt    <= '0;
         active <= 1'b0;
      end else if (i_trig) begin
         cnt    <= CNT_W'(PULSE_CYC);
         active <= 1'b1;
      end else if (cnt != 0) begin
         cnt <= cnt - 1'b1;
      end else begin
         active <= 1'b0;
      end
   end

   assign o_pulse = active ^ i_oedge;     // polarity select

endmodule

//--- sync_unit.sv
// time sync unit top
`timescale 1ns/1ps
`include "sync_defines.svh"

module sync_unit import sync_pkg::*; (
   input  logic                   clk,
   input  logic                   host_clk,          // async reset, active high
   input  logic                   i_pps,
   input  logic                   i_ext_1s,
   input  logic                   i_ext_1m,
   input  logic                   i_sync_iedge,      // 1 = falling input edges
   input  logic                   i_sync_oedge,      // idle level of 1s/1m outputs
   input  logic                   i_mode_set_time,   // 1 = load on minute edge
   input  logic [1:0]             i_type_of_sync,    // sync_src_e code
   input  logic                   i_wr_en,
   input  logic [31:0]            i_wr_data,
   output logic [31:0]            o_time,
   output logic [`SYNC_NFR_W-1:0] o_n_sync,
   output logic [7:0]             o_err_cnt,
   output logic                   o_sync,
   output logic                   o_sync_win,
   output logic                   o_out_1s,
   output logic                   o_out_1m
);

   logic restart;     // realign frame counters
   logic minute;      // host load enable
   logic load_pend;
   logic sec_carry;
   logic min_carry;

   frame_if fbus ();

   // ----------------------------------------------------------------------
   // reference path
   // ----------------------------------------------------------------------
   ref_edge_select u_ref (
      .i_clk(clk), .host_clk(host_clk),
      .i_pps(i_pps), .i_ext_1s(i_ext_1s), .i_ext_1m(i_ext_1m),
      .i_sync_iedge(i_sync_iedge), .i_src(sync_src_e'(i_type_of_sync)),
      .i_load_pend(load_pend), .i_mode_set_time(i_mode_set_time),
      .o_restart(restart), .o_minute(minute)
   );

   frame_timer u_timer (
      .clk(clk), .host_clk(host_clk), .i_restart(restart),
      .i_src(sync_src_e'(i_type_of_sync)), .i_wr_en(i_wr_en), .fb(fbus.timer),
      .o_sync(o_sync), .o_sync_win(o_sync_win), .o_sec_carry(sec_carry),
      .o_err_cnt(o_err_cnt)
   );

   time_of_day u_tod (
      .clk(clk), .host_clk(host_clk), .i_wr_en(i_wr_en), .i_wr_data(i_wr_data),
      .i_minute(minute), .i_sec_carry(sec_carry), .fb(fbus.tod),
      .o_load_pend(load_pend), .o_time(o_time), .o_min_carry(min_carry)
   );

   // ----------------------------------------------------------------------
   // stretched outputs
   // ----------------------------------------------------------------------
   pulse_stretch #(.PULSE_CYC(`SYNC_PULSE_CYC)) u_out_1s (
      .clk(clk), .host_clk(host_clk), .i_trig(sec_carry),
      .i_oedge(i_sync_oedge), .o_pulse(o_out_1s)
   );

   pulse_stretch #(.PULSE_CYC(`SYNC_PULSE_CYC)) u_out_1m (
      .clk(clk), .host_clk(host_clk), .i_trig(min_carry),
      .i_oedge(i_sync_oedge), .o_pulse(o_out_1m)
   );

   assign o_n_sync = fbus.frame_idx;   // frame number within second

endmodule

//--- sync_unit_chk.sv
// sync unit checker
`timescale 1ns/1ps
`include "sync_defines.svh"

module sync_unit_chk (
   input logic        clk,
   input logic        host_clk,      // async reset, active high
   input logic        i_sync_win,
   input logic [31:0] i_time,
   input logic        i_out_1s,
   input logic        i_out_1m,
   input logic        i_oedge        // idle level of the stretched outputs
);

   localparam logic [7:0] MAX_RUN = 8'(`SYNC_PULSE_CYC + 2);

   logic [7:0] run_1s;               // clk the 1s output is away from idle
   logic [7:0] run_1m;

   always_ff @(posedge clk or posedge host_clk) begin
      if (host_clk) begin
         run_1s <= '0;
         run_1m <= '0;
      end else begin
         run_1s <= (i_out_1s != i_oedge) ? run_1s + 8'd1 : 8'd0;
         run_1m <= (i_out_1m != i_oedge) ? run_1m + 8'd1 : 8'd0;
      end
   end

   // ----------------------------------------------------------------------
   // properties
   // ----------------------------------------------------------------------
   a_win_one: assert property (@(posedge clk) disable iff (host_clk)
      i_sync_win |=> !i_sync_win)
      else $error("o_sync_win stayed high for more than one clk");

   a_sec_range: assert property (@(posedge clk) disable iff (host_clk)
      i_time[19:14] <= 6'd59)                   // seconds field
      else $error("o_time seconds field above 59");

   a_1s_idle: assert property (@(posedge clk) disable iff (host_clk)
      run_1s <= MAX_RUN)
      else $error("o_out_1s did not return to idle in time");

   a_1m_idle: assert property (@(posedge clk) disable iff (host_clk)
      run_1m <= MAX_RUN)
      else $error("o_out_1m did not return to idle in time");

endmodule

bind sync_unit sync_unit_chk u_chk (
   .clk(clk), .host_clk(host_clk), .i_sync_win(o_sync_win), .i_time(o_time),
   .i_out_1s(o_out_1s), .i_out_1m(o_out_1m), .i_oedge(i_sync_oedge)
);

//--- tb_sync_unit.sv
// sync unit testbench
`timescale 1ns/1ps

module tb_sync_unit;

   // ----------------------------------------------------------------------
   // DUT signals
   // ----------------------------------------------------------------------
   logic        clk;
   logic        host_clk;          // async reset, active high
   logic        i_pps;
   logic        i_ext_1s;
   logic        i_ext_1m;
   logic        i_sync_iedge;
   logic        i_sync_oedge;
   logic        i_mode_set_time;
   logic [1:0]  i_type_of_sync;
   logic        i_wr_en;
   logic [31:0] i_wr_data;
   logic [31:0] o_time;
   logic [7:0]  o_n_sync;
   logic [7:0]  o_err_cnt;
   logic        o_sync;
   logic        o_sync_win;
   logic        o_out_1s;
   logic        o_out_1m;

   // one entry per data line of the tests file
   string       t_name[$];
   string       t_cmd[$];
   logic [31:0] t_op1[$];
   logic [31:0] t_op2[$];

   int          seed = 59349;      // jitter source
   int          watch_cyc = 0;     // watchdog arms once this is set

   sync_unit UUT (
      .clk(clk), .host_clk(host_clk), .i_pps(i_pps), .i_ext_1s(i_ext_1s),
      .i_ext_1m(i_ext_1m), .i_sync_iedge(i_sync_iedge), .i_sync_oedge(i_sync_oedge),
      .i_mode_set_time(i_mode_set_time), .i_type_of_sync(i_type_of_sync),
      .i_wr_en(i_wr_en), .i_wr_data(i_wr_data), .o_time(o_time), .o_n_sync(o_n_sync),
      .o_err_cnt(o_err_cnt), .o_sync(o_sync), .o_sync_win(o_sync_win),
      .o_out_1s(o_out_1s), .o_out_1m(o_out_1m)
   );

   always #20 clk = ~clk;          // 40 ns period

   task automatic stop_run();
      $display("Test failed");
      $fatal(1, "run stopped on the first error");
   endtask

   // ----------------------------------------------------------------------
   // tests file reader, lines starting with # are skipped
   // ----------------------------------------------------------------------
   task automatic load_table();
      int          fd;
      int          rc;
      int          ch;
      string       tok;
      string       cmd;
      logic [31:0] a;
      logic [31:0] b;
      fd = $fopen("sync_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open sync_tests.txt in the project root");
         stop_run();
      end else begin
         while (!$feof(fd)) begin
            rc = $fscanf(fd, "%s", tok);
            if (rc != 1)
               break;
            if (tok.getc(0) == "#") begin
               ch = $fgetc(fd);                    // drop rest of comment line
               while (ch != "\n" && ch != -1)
                  ch = $fgetc(fd);
            end else if ($fscanf(fd, "%s %h %h", cmd, a, b) != 3) begin
               $display("line of test %s in sync_tests.txt is malformed", tok);
               stop_run();
            end else begin
               t_name.push_back(tok);
               t_cmd.push_back(cmd);
               t_op1.push_back(a);
               t_op2.push_back(b);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic check_value(input string nm, input string what,
                              input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s: %s expected %h, actual %h", nm, what, exp, got);
         stop_run();
      end
   endtask

   // single clk host write strobe
   task automatic host_write(input logic [31:0] d);
      i_wr_data = d;
      i_wr_en   = 1'b1;
      @(negedge clk);
      i_wr_en   = 1'b0;
   endtask

   task automatic set_pin(input logic [31:0] sel, input logic lvl);
      if (sel == 0)
         i_pps = lvl;
      else if (sel == 1)
         i_ext_1s = lvl;
      else if (sel == 2)
         i_ext_1m = lvl;
      else begin
         $display("pulse select %0d does not name an input pin", sel);
         stop_run();
      end
   endtask

   // two clk high pulse, optionally 0..2 clk late
   task automatic pulse_pin(input logic [31:0] sel, input logic jit);
      int r;
      if (jit) begin
         r = $random(seed);
         r = ((r % 3) + 3) % 3;
         repeat (r) @(negedge clk);
      end
      set_pin(sel, 1'b1);
      repeat (2) @(negedge clk);
      set_pin(sel, 1'b0);
   endtask

   // wait for o_out_1s to reach a level, bounded by a window
   task automatic seek_out1s(input string nm, input logic [31:0] win, input logic lvl);
      int n;
      n = 0;
      while (o_out_1s !== lvl && n < int'(win)) begin
         @(negedge clk);
         n++;
      end
      assert (o_out_1s === lvl) else begin
         $display("%s: o_out_1s did not reach level %0b within %0d cycles", nm, lvl, win);
         stop_run();
      end
   endtask

   // ----------------------------------------------------------------------
   // one table entry, always entered on a falling edge
   // ----------------------------------------------------------------------
   task automatic run_step(input int k);
      string       nm;
      string       cmd;
      logic [31:0] a;
      logic [31:0] b;
      nm  = t_name[k];
      cmd = t_cmd[k];
      a   = t_op1[k];
      b   = t_op2[k];
      if (cmd == "config") begin
         i_type_of_sync  = a[1:0];
         i_mode_set_time = a[2];
         i_sync_iedge    = a[3];
         i_sync_oedge    = a[4];
      end else if (cmd == "write")
         host_write(a);
      else if (cmd == "pulse")
         pulse_pin(a, b[0]);
      else if (cmd == "wait")
         repeat (a) @(negedge clk);
      else if (cmd == "seek_out1s")
         seek_out1s(nm, a, b[0]);
      else if (cmd == "check_time")
         check_value(nm, "o_time", o_time & a, b);   // op1 masks fields
      else if (cmd == "check_err")
         check_value(nm, "o_err_cnt", {24'b0, o_err_cnt}, b);
      else if (cmd == "check_n_sync")
         check_value(nm, "o_n_sync", {24'b0, o_n_sync}, b);
      else if (cmd == "check_sync")
         check_value(nm, "o_sync", {31'b0, o_sync}, b);
      else if (cmd == "check_out1s")
         check_value(nm, "o_out_1s", {31'b0, o_out_1s}, b);
      else begin
         $display("test %s uses unknown command %s", nm, cmd);
         stop_run();
      end
   endtask

   initial begin
      int total;
      clk             = 1'b0;
      host_clk        = 1'b1;
      i_pps           = 1'b0;
      i_ext_1s        = 1'b0;
      i_ext_1m        = 1'b0;
      i_sync_iedge    = 1'b0;
      i_sync_oedge    = 1'b0;
      i_mode_set_time = 1'b0;
      i_type_of_sync  = 2'b00;
      i_wr_en         = 1'b0;
      i_wr_data       = '0;
      load_table();
      total = 0;
      foreach (t_cmd[k])
         if (t_cmd[k] == "wait" || t_cmd[k] == "seek_out1s")
            total += int'(t_op1[k]);
      watch_cyc = 2 * total + 1000;
      repeat (8) @(negedge clk);                 // reset held 8 clk
      host_clk = 1'b0;
      // window strobe low and minute output idle straight out of reset
      check_value("reset", "o_sync_win", {31'b0, o_sync_win}, 32'd0);
      check_value("reset", "o_out_1m", {31'b0, o_out_1m}, {31'b0, i_sync_oedge});
      foreach (t_cmd[k])
         run_step(k);
      // last minute carry is long past, so the output sits at idle
      check_value("end", "o_out_1m", {31'b0, o_out_1m}, {31'b0, i_sync_oedge});
      $display("Test completed successfully");
      $finish;
   end

   // watchdog, limit follows the waits in the table
   initial begin
      wait (watch_cyc > 0);
      repeat (watch_cyc) @(posedge clk);
      $display("watchdog expired after %0d cycles before the tests finished", watch_cyc);
      stop_run();
   end

endmodule

//--- sync_tests.txt
# columns: name command op1 op2, operands in hex
# config op1 = {oedge,iedge,mode,src}, pulse op1 = 0 pps 1 ext_1s 2 ext_1m and op2 = jitter
reset    check_time    ffffffff  00000000
reset    check_err     0         0
reset    check_sync    0         0
reset    check_out1s   0         0
load     config        00        0
load     write         29478000  0
load     wait          3         0
load     check_time    ffffc000  29478000
load     wait          19a       0
load     check_time    ffffc000  29480000
roll     write         5fbe8000  0
roll     wait          3         0
roll     check_time    ffffc000  5fbe8000
roll     wait          262       0
roll     check_time    ffffc000  80004000
pps      config        01        0
pps      wait          3c        0
pps      check_n_sync  0         1
pps      pulse         0         1
pps      wait          4         0
pps      check_n_sync  0         0
pps      check_err     0         1
pps      write         00000000  0
pps      check_err     0         0
pps      wait          3f        0
pps      pulse         0         1
pps      wait          4         0
pps      check_err     0         1
pps      write         0420c000  0
pps      check_err     0         0
pps      wait          2         0
pps      check_time    ffffc000  0420c000
defer    config        05        0
defer    write         32200000  0
defer    wait          5         0
defer    check_time    ffffc000  0420c000
defer    pulse         2         0
defer    wait          5         0
defer    check_time    ffffc000  32200000
stretch  config        11        0
stretch  wait          14        0
stretch  check_out1s   0         1
stretch  pulse         0         1
stretch  seek_out1s    1e        0
stretch  wait          23        0
stretch  check_out1s   0         1

//--- verilog.f
+incdir+.
sync_pkg.sv
frame_if.sv
ref_edge_select.sv
frame_timer.sv
time_of_day.sv
pulse_stretch.sv
sync_unit.sv
sync_unit_chk.sv
tb_sync_unit.sv

//--- run.sh
#!/bin/sh
# verilator build and run of the sync unit testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_sync_unit
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_sync_unit)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
